//--- mips_pkg.sv
package mips_pkg;

	// ------------------------------------------------------------------------
	// Widths fixed by the ISA
	// ------------------------------------------------------------------------

	typedef logic [31:0] word_t;     // Register, operand and result word
	typedef logic [4:0]  reg_idx_t;  // Register index
	typedef logic [15:0] imm_t;      // Instruction immediate field

	// ALU control
	//   bit 3    unsigned compare for set-less-than
	//   bit 2    invert B, carry in of one
	//   bits 1:0 result select: AND, OR, sum, set-less-than
	typedef logic [3:0]  alu_ctl_t;

	// ------------------------------------------------------------------------
	// ALU control codes
	// ------------------------------------------------------------------------

	localparam alu_ctl_t ALU_AND  = 4'b0000;
	localparam alu_ctl_t ALU_OR   = 4'b0001;
	localparam alu_ctl_t ALU_ADD  = 4'b0010;
	localparam alu_ctl_t ALU_SUB  = 4'b0110;  // a + ~b + 1
	localparam alu_ctl_t ALU_SLT  = 4'b0111;  // Signed, N xor V
	localparam alu_ctl_t ALU_SLTU = 4'b1111;  // Unsigned, borrow out

	// Select field values in alu_ctl_t[1:0]
	localparam logic [1:0] SEL_AND = 2'b00;
	localparam logic [1:0] SEL_OR  = 2'b01;
	localparam logic [1:0] SEL_SUM = 2'b10;
	localparam logic [1:0] SEL_SLT = 2'b11;

	// ------------------------------------------------------------------------
	// Registers
	// ------------------------------------------------------------------------

	// Hardwired zero, never written and never forwarded
	localparam reg_idx_t REG_ZERO = 5'd0;

endpackage

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic              clk,
	input  mips_pkg::reg_idx_t read_addr_a,
	input  mips_pkg::reg_idx_t read_addr_b,
	input  logic              write_en,
	input  mips_pkg::reg_idx_t write_addr,
	input  mips_pkg::word_t    write_data,
	output mips_pkg::word_t    read_data_a,
	output mips_pkg::word_t    read_data_b
);

	mips_pkg::word_t regs [1:31];  // r0 has no storage

	always_ff @(posedge clk) begin
		if (write_en && write_addr != mips_pkg::REG_ZERO)
			regs[write_addr] <= write_data;
	end

	// Write-through so a read in the write cycle sees the new value
	always_comb begin
		if (read_addr_a == mips_pkg::REG_ZERO)
			read_data_a = '0;
		else if (write_en && write_addr == read_addr_a)
			read_data_a = write_data;
		else
			read_data_a = regs[read_addr_a];
	end

	always_comb begin
		if (read_addr_b == mips_pkg::REG_ZERO)
			read_data_b = '0;
		else if (write_en && write_addr == read_addr_b)
			read_data_b = write_data;
		else
			read_data_b = regs[read_addr_b];
	end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic               clk,
	input  logic               reset,
	input  logic               issue_valid,
	input  mips_pkg::reg_idx_t rs,
	input  mips_pkg::reg_idx_t rt,
	input  mips_pkg::reg_idx_t rd,
	input  mips_pkg::alu_ctl_t alu_ctl,
	input  mips_pkg::imm_t     imm,
	input  logic               use_imm,
	input  logic               sign_ext,
	input  logic               shift16,
	input  logic               reg_write,
	output mips_pkg::reg_idx_t rf_addr_a,
	output mips_pkg::reg_idx_t rf_addr_b,
	input  mips_pkg::word_t    rf_data_a,
	input  mips_pkg::word_t    rf_data_b,
	output logic               ex_valid,
	output mips_pkg::reg_idx_t ex_rs,
	output mips_pkg::reg_idx_t ex_rt,
	output mips_pkg::reg_idx_t ex_rd,
	output mips_pkg::alu_ctl_t ex_alu_ctl,
	output logic               ex_use_imm,
	output logic               ex_reg_write,
	output mips_pkg::word_t    ex_op_a,
	output mips_pkg::word_t    ex_op_b,
	output mips_pkg::word_t    ex_imm
);

	mips_pkg::word_t imm_ext;

	assign rf_addr_a = rs;
	assign rf_addr_b = rt;

	// Load-upper takes priority over extension
	always_comb begin
		if (shift16)
			imm_ext = {imm, 16'h0000};
		else if (sign_ext)
			imm_ext = {{16{imm[15]}}, imm};
		else
			imm_ext = {16'h0000, imm};
	end

	// ------------------------------------------------------------------------
	// Decode to execute register
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ex_valid     <= 1'b0;
			ex_reg_write <= 1'b0;
		end else begin
			ex_valid     <= issue_valid;
			ex_reg_write <= issue_valid & reg_write;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			ex_rs      <= rs;
			ex_rt      <= rt;
			ex_rd      <= rd;
			ex_alu_ctl <= alu_ctl;
			ex_use_imm <= use_imm;
			ex_op_a    <= rf_data_a;
			ex_op_b    <= rf_data_b;
			ex_imm     <= imm_ext;
		end
	end

endmodule

//--- operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
	input  mips_pkg::reg_idx_t ex_rs,
	input  mips_pkg::reg_idx_t ex_rt,
	input  mips_pkg::word_t    ex_op_a,
	input  mips_pkg::word_t    ex_op_b,
	input  logic               wb_valid,
	input  mips_pkg::reg_idx_t wb_reg,
	input  mips_pkg::word_t    wb_data,
	output mips_pkg::word_t    fwd_a,
	output mips_pkg::word_t    fwd_b
);

	logic wb_live;
	logic hit_a;
	logic hit_b;

	// Writeback register is the only source, r0 never matches
	assign wb_live = wb_valid && (wb_reg != mips_pkg::REG_ZERO);

	assign hit_a = wb_live && (wb_reg == ex_rs);
	assign hit_b = wb_live && (wb_reg == ex_rt);

	assign fwd_a = hit_a ? wb_data : ex_op_a;
	assign fwd_b = hit_b ? wb_data : ex_op_b;

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
	input  mips_pkg::word_t    a,
	input  mips_pkg::word_t    b,
	input  mips_pkg::alu_ctl_t ctl,
	output mips_pkg::word_t    result
);

	mips_pkg::word_t b_in;
	mips_pkg::word_t sum;
	mips_pkg::word_t slt_word;
	logic [32:0]     carry;
	logic            flag_n;
	logic            flag_c;
	logic            flag_v;
	logic            less;

	// ------------------------------------------------------------------------
	// Ripple-carry adder
	// ------------------------------------------------------------------------

	assign b_in     = ctl[2] ? ~b : b;
	assign carry[0] = ctl[2];  // Two's complement for subtract

	genvar i;
	generate
		for (i = 0; i < 32; i++) begin : g_bit
			assign sum[i]     = a[i] ^ b_in[i] ^ carry[i];
			assign carry[i+1] = (a[i] & b_in[i]) | (a[i] & carry[i]) | (b_in[i] & carry[i]);
		end
	endgenerate

	assign flag_n = sum[31];
	assign flag_c = carry[32];
	assign flag_v = carry[32] ^ carry[31];

	// No carry out of a - b means a < b unsigned
	assign less     = ctl[3] ? ~flag_c : (flag_n ^ flag_v);
	assign slt_word = {31'b0, less};

	// ------------------------------------------------------------------------
	// Result select
	// ------------------------------------------------------------------------

	always_comb begin
		case (ctl[1:0])
			mips_pkg::SEL_AND: result = a & b;
			mips_pkg::SEL_OR:  result = a | b;
			mips_pkg::SEL_SUM: result = sum;
			mips_pkg::SEL_SLT: result = slt_word;
			default:           result = sum;
		endcase
	end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic               clk,
	input  logic               reset,
	input  logic               ex_valid,
	input  mips_pkg::reg_idx_t ex_rs,
	input  mips_pkg::reg_idx_t ex_rt,
	input  mips_pkg::reg_idx_t ex_rd,
	input  mips_pkg::alu_ctl_t ex_alu_ctl,
	input  logic               ex_use_imm,
	input  logic               ex_reg_write,
	input  mips_pkg::word_t    ex_op_a,
	input  mips_pkg::word_t    ex_op_b,
	input  mips_pkg::word_t    ex_imm,
	output logic               wb_valid,
	output mips_pkg::reg_idx_t wb_reg,
	output mips_pkg::word_t    wb_data
);

	mips_pkg::word_t fwd_a;
	mips_pkg::word_t fwd_b;
	mips_pkg::word_t alu_b;
	mips_pkg::word_t alu_result;

	operand_forward u_operand_forward (
		.ex_rs    (ex_rs),
		.ex_rt    (ex_rt),
		.ex_op_a  (ex_op_a),
		.ex_op_b  (ex_op_b),
		.wb_valid (wb_valid),
		.wb_reg   (wb_reg),
		.wb_data  (wb_data),
		.fwd_a    (fwd_a),
		.fwd_b    (fwd_b)
	);

	assign alu_b = ex_use_imm ? ex_imm : fwd_b;

	alu u_alu (.a(fwd_a), .b(alu_b), .ctl(ex_alu_ctl), .result(alu_result));

	// Writeback register, also feeds the regfile write port
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wb_valid <= 1'b0;
			wb_reg   <= '0;
			wb_data  <= '0;
		end else begin
			wb_valid <= ex_valid & ex_reg_write;
			if (ex_valid) begin
				wb_reg  <= ex_rd;
				wb_data <= alu_result;
			end
		end
	end

endmodule

//--- mips_exec_core.sv
`timescale 1ns/1ps

module mips_exec_core (
	input  logic               clk,
	input  logic               reset,
	input  logic               issue_valid,
	input  mips_pkg::reg_idx_t rs,
	input  mips_pkg::reg_idx_t rt,
	input  mips_pkg::reg_idx_t rd,
	input  mips_pkg::alu_ctl_t alu_ctl,
	input  mips_pkg::imm_t     imm,
	input  logic               use_imm,
	input  logic               sign_ext,
	input  logic               shift16,
	input  logic               reg_write,
	output logic               wb_valid,
	output mips_pkg::reg_idx_t wb_reg,
	output mips_pkg::word_t    wb_data
);

	mips_pkg::reg_idx_t rf_addr_a, rf_addr_b;
	mips_pkg::word_t    rf_data_a, rf_data_b;

	logic               ex_valid, ex_use_imm, ex_reg_write;
	mips_pkg::reg_idx_t ex_rs, ex_rt, ex_rd;
	mips_pkg::alu_ctl_t ex_alu_ctl;
	mips_pkg::word_t    ex_op_a, ex_op_b, ex_imm;

	reg_file u_reg_file (
		.clk(clk), .read_addr_a(rf_addr_a), .read_addr_b(rf_addr_b),
		.write_en(wb_valid), .write_addr(wb_reg), .write_data(wb_data),
		.read_data_a(rf_data_a), .read_data_b(rf_data_b)
	);

	decode_stage u_decode_stage (
		.clk(clk), .reset(reset), .issue_valid(issue_valid),
		.rs(rs), .rt(rt), .rd(rd), .alu_ctl(alu_ctl), .imm(imm),
		.use_imm(use_imm), .sign_ext(sign_ext), .shift16(shift16), .reg_write(reg_write),
		.rf_addr_a(rf_addr_a), .rf_addr_b(rf_addr_b),
		.rf_data_a(rf_data_a), .rf_data_b(rf_data_b),
		.ex_valid(ex_valid), .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd),
		.ex_alu_ctl(ex_alu_ctl), .ex_use_imm(ex_use_imm), .ex_reg_write(ex_reg_write),
		.ex_op_a(ex_op_a), .ex_op_b(ex_op_b), .ex_imm(ex_imm)
	);

	execute_stage u_execute_stage (
		.clk(clk), .reset(reset), .ex_valid(ex_valid),
		.ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd), .ex_alu_ctl(ex_alu_ctl),
		.ex_use_imm(ex_use_imm), .ex_reg_write(ex_reg_write),
		.ex_op_a(ex_op_a), .ex_op_b(ex_op_b), .ex_imm(ex_imm),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
	);

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	localparam time HALF_PERIOD = 2ns;  // 4 ns clock

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

//--- tb_mips_exec_core.sv
`timescale 1ns/1ps

module tb_mips_exec_core;

	localparam int unsigned RAND_SEED = 32'he029_a8fd;
	localparam int NUM_TESTS = 6;
	localparam int unsigned CYCLE_LIMIT = 45 + 30 + 10 + 45 + 15 + 260 + 60;  // Tests plus margin

	logic               clk, reset, issue_valid;
	logic               use_imm, sign_ext, shift16, reg_write;
	mips_pkg::reg_idx_t rs, rt, rd, wb_reg;
	mips_pkg::alu_ctl_t alu_ctl;
	mips_pkg::imm_t     imm;
	logic               wb_valid;
	mips_pkg::word_t    wb_data;

	mips_pkg::word_t    model_rf [32];  // Reference registers, sequential order
	int unsigned        exp_due [$];    // Cycle a writeback must show up
	mips_pkg::reg_idx_t exp_reg [$];
	mips_pkg::word_t    exp_data [$];
	int unsigned        cyc = 0;
	int unsigned        seed_ret;
	int                 err_count = 0;
	int                 test_errs = 0;
	int                 tests_passed = 0;
	logic               checking = 1'b0;

	tb_clock u_tb_clock (.clk(clk));

	mips_exec_core u_mips_exec_core (
		.clk(clk), .reset(reset), .issue_valid(issue_valid),
		.rs(rs), .rt(rt), .rd(rd), .alu_ctl(alu_ctl), .imm(imm),
		.use_imm(use_imm), .sign_ext(sign_ext), .shift16(shift16), .reg_write(reg_write),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	always @(posedge clk) cyc <= cyc + 1;

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------

	function automatic mips_pkg::word_t form_imm(mips_pkg::imm_t v, logic sx, logic up);
		if (up)
			return {v, 16'h0000};
		if (sx)
			return {{16{v[15]}}, v};
		return {16'h0000, v};
	endfunction

	function automatic mips_pkg::word_t alu_model(mips_pkg::alu_ctl_t ctl,
			mips_pkg::word_t a, mips_pkg::word_t b);
		case (ctl)
			mips_pkg::ALU_AND:  return a & b;
			mips_pkg::ALU_OR:   return a | b;
			mips_pkg::ALU_ADD:  return a + b;
			mips_pkg::ALU_SUB:  return a - b;
			mips_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
			mips_pkg::ALU_SLTU: return {31'b0, a < b};
			default:            return 'x;
		endcase
	endfunction

	task automatic check_word(string what, mips_pkg::word_t got, mips_pkg::word_t exp);
		if (got !== exp) begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic check_reg(string what, mips_pkg::reg_idx_t got, mips_pkg::reg_idx_t exp);
		if (got !== exp) begin
			$display("ERR %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
			err_count++;
		end
	endtask

	// Writeback is visible 2 cycles after the issue edge
	always @(negedge clk) begin
		if (checking) begin
			if (exp_due.size() != 0 && exp_due[0] == cyc) begin
				if (wb_valid !== 1'b1) begin
					$display("Missing writeback to r%0d at time %0t", exp_reg[0], $time);
					err_count++;
				end else begin
					check_reg("wb_reg", wb_reg, exp_reg[0]);
					check_word("wb_data", wb_data, exp_data[0]);
				end
				exp_due.delete(0);
				exp_reg.delete(0);
				exp_data.delete(0);
			end else if (wb_valid !== 1'b0) begin
				$display("Unexpected writeback to r%0d at time %0t", wb_reg, $time);
				err_count++;
			end
		end
		if (cyc > CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	task automatic issue(mips_pkg::alu_ctl_t ctl, mips_pkg::reg_idx_t s, mips_pkg::reg_idx_t t,
			mips_pkg::reg_idx_t d, mips_pkg::imm_t iv, logic ui, logic sx, logic up, logic wr);
		mips_pkg::word_t a;
		mips_pkg::word_t b;
		mips_pkg::word_t r;
		@(posedge clk);
		issue_valid <= 1'b1;
		rs          <= s;
		rt          <= t;
		rd          <= d;
		alu_ctl     <= ctl;
		imm         <= iv;
		use_imm     <= ui;
		sign_ext    <= sx;
		shift16     <= up;
		reg_write   <= wr;
		a = model_rf[s];
		b = ui ? form_imm(iv, sx, up) : model_rf[t];
		r = alu_model(ctl, a, b);
		if (wr) begin
			exp_due.push_back(cyc + 3);  // cyc still holds the count before this edge
			exp_reg.push_back(d);
			exp_data.push_back(r);
			if (d != mips_pkg::REG_ZERO)
				model_rf[d] = r;
		end
	endtask

	task automatic rop(mips_pkg::alu_ctl_t ctl, mips_pkg::reg_idx_t d,
			mips_pkg::reg_idx_t s, mips_pkg::reg_idx_t t);
		issue(ctl, s, t, d, 16'h0000, 1'b0, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic iop(mips_pkg::alu_ctl_t ctl, mips_pkg::reg_idx_t d,
			mips_pkg::reg_idx_t s, mips_pkg::imm_t iv, logic sx);
		issue(ctl, s, mips_pkg::REG_ZERO, d, iv, 1'b1, sx, 1'b0, 1'b1);
	endtask

	task automatic idle();
		@(posedge clk);
		issue_valid <= 1'b0;
	endtask

	task automatic drain();
		idle();
		while (exp_due.size() != 0)
			@(negedge clk);
	endtask

	// Load-upper then OR in the low half
	task automatic load_word(mips_pkg::reg_idx_t d, mips_pkg::word_t v);
		issue(mips_pkg::ALU_OR, mips_pkg::REG_ZERO, mips_pkg::REG_ZERO, d, v[31:16],
			1'b1, 1'b0, 1'b1, 1'b1);
		iop(mips_pkg::ALU_OR, d, d, v[15:0], 1'b0);
	endtask

	task automatic end_test(string name);
		if (err_count == test_errs) begin
			tests_passed++;
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d errors", name, err_count - test_errs);
		end
		test_errs = err_count;
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------

	task automatic test_reset_load();
		mips_pkg::word_t v;
		repeat (3) idle();  // No writeback before the first issue
		for (int i = 1; i < 32; i++) begin
			v = $urandom;
			iop(mips_pkg::ALU_ADD, i[4:0], mips_pkg::REG_ZERO, v[15:0], v[16]);
		end
		drain();
		end_test("reset_and_load");
	endtask

	task automatic test_alu();
		load_word(5'd1, 32'h7fff_ffff);
		load_word(5'd2, 32'h8000_0000);
		load_word(5'd3, 32'h0000_0001);
		load_word(5'd4, 32'hf0f0_f0f0);
		load_word(5'd5, 32'h3c3c_3c3c);
		rop(mips_pkg::ALU_ADD, 5'd6, 5'd1, 5'd3);   // Overflow wrap
		rop(mips_pkg::ALU_SUB, 5'd7, 5'd2, 5'd3);   // Underflow wrap
		rop(mips_pkg::ALU_SLT, 5'd8, 5'd2, 5'd3);
		rop(mips_pkg::ALU_SLTU, 5'd9, 5'd2, 5'd3);
		rop(mips_pkg::ALU_SLT, 5'd10, 5'd3, 5'd2);
		rop(mips_pkg::ALU_SLTU, 5'd11, 5'd3, 5'd2);
		rop(mips_pkg::ALU_AND, 5'd12, 5'd4, 5'd5);
		rop(mips_pkg::ALU_OR, 5'd13, 5'd4, 5'd5);
		rop(mips_pkg::ALU_SUB, 5'd14, 5'd3, 5'd2);
		drain();
		end_test("alu_functions");
	endtask

	task automatic test_imm();
		iop(mips_pkg::ALU_ADD, 5'd15, mips_pkg::REG_ZERO, 16'h8001, 1'b1);
		iop(mips_pkg::ALU_ADD, 5'd16, mips_pkg::REG_ZERO, 16'h8001, 1'b0);
		issue(mips_pkg::ALU_OR, mips_pkg::REG_ZERO, mips_pkg::REG_ZERO, 5'd17, 16'h8001,
			1'b1, 1'b0, 1'b1, 1'b1);
		drain();
		end_test("immediate_forms");
	endtask

	// Gap 0 forwards, gap 1 uses the bypass, gap 2 reads the regfile
	task automatic test_forward();
		mips_pkg::imm_t k;
		k = 16'h0123;
		for (int gap = 0; gap < 3; gap++) begin
			for (int pos = 0; pos < 2; pos++) begin
				k = k + 16'h0011;
				iop(mips_pkg::ALU_ADD, 5'd20, mips_pkg::REG_ZERO, k, 1'b0);
				repeat (gap) idle();
				if (pos == 0)
					rop(mips_pkg::ALU_ADD, 5'd21, 5'd20, 5'd3);
				else
					rop(mips_pkg::ALU_SUB, 5'd21, 5'd1, 5'd20);
				drain();
			end
		end
		end_test("dependent_ops");
	endtask

	task automatic test_zero_reg();
		iop(mips_pkg::ALU_ADD, mips_pkg::REG_ZERO, mips_pkg::REG_ZERO, 16'h0055, 1'b0);
		rop(mips_pkg::ALU_ADD, 5'd22, mips_pkg::REG_ZERO, mips_pkg::REG_ZERO);
		rop(mips_pkg::ALU_OR, 5'd23, 5'd3, mips_pkg::REG_ZERO);
		issue(mips_pkg::ALU_ADD, mips_pkg::REG_ZERO, mips_pkg::REG_ZERO, 5'd3, 16'h7777,
			1'b1, 1'b0, 1'b0, 1'b0);  // reg_write clear
		rop(mips_pkg::ALU_OR, 5'd24, 5'd3, mips_pkg::REG_ZERO);
		drain();
		end_test("zero_register");
	endtask

	task automatic test_random();
		mips_pkg::word_t    rv;
		mips_pkg::word_t    rw;
		mips_pkg::alu_ctl_t ctl;
		for (int n = 0; n < 200; n++) begin
			rv = $urandom;
			rw = $urandom;
			if (rv[2:0] == 3'd0)
				idle();
			case (rv[10:8])
				3'd0:    ctl = mips_pkg::ALU_AND;
				3'd1:    ctl = mips_pkg::ALU_OR;
				3'd3:    ctl = mips_pkg::ALU_SUB;
				3'd4:    ctl = mips_pkg::ALU_SLT;
				3'd5:    ctl = mips_pkg::ALU_SLTU;
				default: ctl = mips_pkg::ALU_ADD;
			endcase
			issue(ctl, rv[15:11], rv[20:16], rv[25:21], rw[15:0], rw[16], rw[17],
				rw[18] & rw[19], rw[20] | rw[21]);
		end
		drain();
		end_test("random_stream");
	endtask

	initial begin
		seed_ret    = $urandom(RAND_SEED);
		reset       = 1'b1;
		issue_valid = 1'b0;
		rs          = '0;
		rt          = '0;
		rd          = '0;
		alu_ctl     = mips_pkg::ALU_ADD;
		imm         = '0;
		use_imm     = 1'b0;
		sign_ext    = 1'b0;
		shift16     = 1'b0;
		reg_write   = 1'b0;
		model_rf[0] = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		checking = 1'b1;
		test_reset_load();
		test_alu();
		test_imm();
		test_forward();
		test_zero_reg();
		test_random();
		$display("Tests run %0d, passed %0d, errors %0d", NUM_TESTS, tests_passed, err_count);
		if (err_count == 0 && tests_passed == NUM_TESTS)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- sim.f
mips_pkg.sv
reg_file.sv
decode_stage.sv
operand_forward.sv
alu.sv
execute_stage.sv
mips_exec_core.sv
tb_clock.sv
tb_mips_exec_core.sv

//--- Bender.yml
package:
  name: mips_exec_core

sources:
  - mips_pkg.sv
  - reg_file.sv
  - decode_stage.sv
  - operand_forward.sv
  - alu.sv
  - execute_stage.sv
  - mips_exec_core.sv
  - target: simulation
    files:
      - tb_clock.sv
      - tb_mips_exec_core.sv
